// ==== bridge_consts.svh ====
/*
 * DMA write bridge constants
 * widths, tag count, power-up delay and DMA response codes
 */
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// tag space
`define BR_TAG_W      4
`define BR_TAGS       16

// command payload widths
`define BR_DATA_W     64
`define BR_EA_W       32
`define BR_BE_W       8

// cycles from reset release to start of free-tag fill
`define BR_PWRUP_CYC  14

// one-hot DMA response codes
`define BR_RESP_GOOD  3'b001
`define BR_RESP_RETRY 3'b010
`define BR_RESP_BAD   3'b100

`endif

// ==== bridge_pkg.sv ====
/*
 * DMA write bridge types
 * command, response and response-code types shared across the bridge
 */
`include "bridge_consts.svh"

package bridge_pkg;

   // ====================
   // response codes
   // ====================

   // one-hot code carried by every DMA response
   typedef enum logic [2:0] {
      RESP_GOOD  = `BR_RESP_GOOD,
      RESP_RETRY = `BR_RESP_RETRY,
      RESP_BAD   = `BR_RESP_BAD
   } resp_code_e;

   // ====================
   // commands
   // ====================

   // local write command, 104 bits
   typedef struct packed {
      logic [`BR_DATA_W-1:0] data;
      logic [`BR_EA_W-1:0]   ea;
      logic [`BR_BE_W-1:0]   be;
   } lcl_cmd_t;

   // command on the DMA side, local command plus tag
   typedef struct packed {
      lcl_cmd_t              cmd;
      logic [`BR_TAG_W-1:0]  tag;
   } dma_cmd_t;

   // ====================
   // responses
   // ====================

   typedef struct packed {
      logic [`BR_TAG_W-1:0]  tag;
      resp_code_e            code;
   } dma_resp_t;

   // ok high for a good response, low for bad
   typedef struct packed {
      logic [`BR_TAG_W-1:0]  tag;
      logic                  ok;
   } lcl_resp_t;

endpackage

// ==== tag_fifo.sv ====
/*
 * tag FIFO
 * first-word-fall-through register-array FIFO, BR_TAGS deep,
 * with occupancy count; holds free tags or retry tags
 */
`include "bridge_consts.svh"

module tag_fifo #(
   parameter int DATA_W = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [DATA_W-1:0]    din,
   input  logic                 wr_en,
   input  logic                 rd_en,
   output logic [DATA_W-1:0]    dout,
   output logic                 empty,
   output logic                 full,
   output logic [`BR_TAG_W:0]   count
);

   localparam logic [`BR_TAG_W:0] DEPTH = `BR_TAGS;

   logic [DATA_W-1:0]    mem [`BR_TAGS];
   logic [`BR_TAG_W-1:0] wr_ptr;
   logic [`BR_TAG_W-1:0] rd_ptr;
   logic [`BR_TAG_W:0]   cnt;

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         // simultaneous push and pop leaves the count alone
         case ({wr_en, rd_en})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= din;
   end

   // head word is visible without a read request
   assign dout  = mem[rd_ptr];
   assign empty = (cnt == '0);
   assign full  = (cnt == DEPTH);
   assign count = cnt;

   // the producer must never push into a full queue
   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !full);

   // the consumer must only pop a valid head
   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> !empty);

endmodule

// ==== tag_pool.sv ====
/*
 * tag pool
 * fills the free-tag FIFO with every tag after power-up, hands out
 * the head tag on request and takes released tags back
 */
`include "bridge_consts.svh"

module tag_pool (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 tag_take,
   output logic [`BR_TAG_W-1:0] free_tag,
   output logic                 tag_avail,
   input  logic                 rel_valid,
   input  logic [`BR_TAG_W-1:0] rel_tag,
   output logic                 all_free
);

   // keep one spare tag so a registered ready never overshoots the pool
   localparam logic [`BR_TAG_W:0] AVAIL_MIN = 2;

   logic [4:0]           pwr_cnt;
   logic                 fill_start;
   logic                 fill_active;
   logic                 fill_done;
   logic [`BR_TAG_W-1:0] fill_cnt;
   logic                 fifo_wr_q;
   logic [`BR_TAG_W-1:0] fifo_din_q;
   logic [`BR_TAG_W:0]   free_cnt;

   // ====================
   // power-up fill
   // ====================

   // counter stops once the wait is over
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pwr_cnt <= '0;
      else if (pwr_cnt != 5'(`BR_PWRUP_CYC))
         pwr_cnt <= pwr_cnt + 1'b1;
   end

   // one-cycle pulse on the last wait cycle
   assign fill_start = (pwr_cnt == 5'(`BR_PWRUP_CYC - 1));

   // sequencer walks tags 0 to BR_TAGS-1, one per cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fill_active <= 1'b0;
         fill_done   <= 1'b0;
         fill_cnt    <= '0;
      end
      else
      begin
         if (fill_start)
            fill_active <= 1'b1;
         else if (fill_active && (&fill_cnt))
            fill_active <= 1'b0;
         if (fill_active && (&fill_cnt))
            fill_done <= 1'b1;
         if (fill_active)
            fill_cnt <= fill_cnt + 1'b1;
      end
   end

   // ====================
   // free-tag FIFO
   // ====================

   // fill and release share one registered write port
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         fifo_wr_q <= 1'b0;
      else
         fifo_wr_q <= fill_active || rel_valid;
   end

   always_ff @(posedge clk)
   begin
      fifo_din_q <= fill_active ? fill_cnt : rel_tag;
   end

   tag_fifo #(
      .DATA_W (`BR_TAG_W)
   ) free_fifo_i (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (fifo_din_q),
      .wr_en (fifo_wr_q),
      .rd_en (tag_take),
      .dout  (free_tag),
      .empty (),
      .full  (all_free),
      .count (free_cnt)
   );

   // no tag leaves before the pool is complete
   assign tag_avail = fill_done && (free_cnt >= AVAIL_MIN);

   // a release needs a tag that is out on the DMA side
   a_no_surplus_release : assert property (@(posedge clk) disable iff (!rst_n)
      rel_valid |-> !all_free);

endmodule

// ==== resp_retry_ctrl.sv ====
/*
 * response and retry control
 * sorts DMA responses by code, queues retry tags, releases finished
 * tags and reports them locally; raises a hold under retry pressure
 */
`include "bridge_consts.svh"

module resp_retry_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  dma_resp_valid,
   input  bridge_pkg::dma_resp_t dma_resp,
   output logic                  rel_valid,
   output logic [`BR_TAG_W-1:0]  rel_tag,
   output logic                  lcl_resp_valid,
   output bridge_pkg::lcl_resp_t lcl_resp,
   input  logic                  retry_pop,
   output logic                  retry_pending,
   output logic [`BR_TAG_W-1:0]  retry_head,
   output logic                  retry_hold
);

   localparam logic [`BR_TAG_W:0] HOLD_LVL = `BR_TAGS / 2;

   logic                 is_good;
   logic                 is_retry;
   logic                 is_bad;
   logic                 rty_wr_q;
   logic [`BR_TAG_W-1:0] rty_tag_q;
   logic                 rty_empty;
   logic [`BR_TAG_W:0]   rty_cnt;

   // single decode of the one-hot code
   assign is_good  = (dma_resp.code == bridge_pkg::RESP_GOOD);
   assign is_retry = (dma_resp.code == bridge_pkg::RESP_RETRY);
   assign is_bad   = (dma_resp.code == bridge_pkg::RESP_BAD);

   // ====================
   // finished tags
   // ====================

   // tag goes back to the pool, which registers it
   assign rel_valid = dma_resp_valid && (is_good || is_bad);
   assign rel_tag   = dma_resp.tag;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lcl_resp_valid <= 1'b0;
      else
         lcl_resp_valid <= rel_valid;
   end

   always_ff @(posedge clk)
   begin
      lcl_resp.tag <= dma_resp.tag;
      lcl_resp.ok  <= is_good;
   end

   // ====================
   // retry queue
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rty_wr_q <= 1'b0;
      else
         rty_wr_q <= dma_resp_valid && is_retry;
   end

   always_ff @(posedge clk)
   begin
      rty_tag_q <= dma_resp.tag;
   end

   tag_fifo #(
      .DATA_W (`BR_TAG_W)
   ) retry_fifo_i (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (rty_tag_q),
      .wr_en (rty_wr_q),
      .rd_en (retry_pop),
      .dout  (retry_head),
      .empty (rty_empty),
      .full  (),
      .count (rty_cnt)
   );

   assign retry_pending = !rty_empty;

   // hold new commands from half full until the queue drains
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         retry_hold <= 1'b0;
      else if (rty_empty)
         retry_hold <= 1'b0;
      else if (rty_cnt >= HOLD_LVL)
         retry_hold <= 1'b1;
   end

   a_code_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      dma_resp_valid |-> $onehot(dma_resp.code));

endmodule

// ==== cmd_buffer.sv ====
/*
 * command buffer
 * one local command per tag, kept for re-issue on retry;
 * synchronous write, registered read
 */
`include "bridge_consts.svh"

module cmd_buffer (
   input  logic                 clk,
   input  logic                 wr_en,
   input  logic [`BR_TAG_W-1:0] wr_tag,
   input  bridge_pkg::lcl_cmd_t wr_cmd,
   input  logic [`BR_TAG_W-1:0] rd_tag,
   output bridge_pkg::lcl_cmd_t rd_cmd
);

   bridge_pkg::lcl_cmd_t mem [`BR_TAGS];

   // write port, filled one cycle after accept
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_tag] <= wr_cmd;
   end

   // read port, data one cycle after the address
   // a tag is never read and written in the same cycle
   always_ff @(posedge clk)
   begin
      rd_cmd <= mem[rd_tag];
   end

endmodule

// ==== cmd_issue.sv ====
/*
 * command issue
 * accepts local commands, picks new or retried commands and drives
 * the DMA command port two cycles after the decision
 */
`include "bridge_consts.svh"

module cmd_issue (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 lcl_cmd_valid,
   input  bridge_pkg::lcl_cmd_t lcl_cmd,
   output logic                 lcl_cmd_ready,
   input  logic                 dma_cmd_ready,
   output logic                 dma_cmd_valid,
   output bridge_pkg::dma_cmd_t dma_cmd,
   output logic                 tag_take,
   input  logic [`BR_TAG_W-1:0] free_tag,
   input  logic                 tag_avail,
   output logic                 retry_pop,
   input  logic                 retry_pending,
   input  logic [`BR_TAG_W-1:0] retry_head,
   input  logic                 retry_hold,
   output logic                 buf_wr_en,
   output logic [`BR_TAG_W-1:0] buf_wr_tag,
   output bridge_pkg::lcl_cmd_t buf_wr_cmd,
   output logic [`BR_TAG_W-1:0] buf_rd_tag,
   input  bridge_pkg::lcl_cmd_t buf_rd_cmd
);

   logic                 accept;
   logic                 new_vld_q;
   bridge_pkg::lcl_cmd_t new_cmd_q;
   logic [`BR_TAG_W-1:0] new_tag_q;
   logic                 rty_vld_q;
   logic [`BR_TAG_W-1:0] rty_tag_q;

   // ====================
   // decisions
   // ====================

   // ready needs a spare tag, DMA credit and no retry pressure
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lcl_cmd_ready <= 1'b0;
      else
         lcl_cmd_ready <= tag_avail && dma_cmd_ready && !retry_hold;
   end

   assign accept   = lcl_cmd_valid && lcl_cmd_ready;
   assign tag_take = accept;

   // retries only use cycles without a local accept
   assign retry_pop  = retry_pending && dma_cmd_ready && !accept;
   assign buf_rd_tag = retry_head;

   // ====================
   // alignment stage
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         new_vld_q <= 1'b0;
         rty_vld_q <= 1'b0;
      end
      else
      begin
         new_vld_q <= accept;
         rty_vld_q <= retry_pop;
      end
   end

   always_ff @(posedge clk)
   begin
      new_cmd_q <= lcl_cmd;
      new_tag_q <= free_tag;
      rty_tag_q <= retry_head;
   end

   // new command is stored while it moves to the DMA port
   assign buf_wr_en  = new_vld_q;
   assign buf_wr_tag = new_tag_q;
   assign buf_wr_cmd = new_cmd_q;

   // ====================
   // DMA port
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         dma_cmd_valid <= 1'b0;
      else
         dma_cmd_valid <= new_vld_q || rty_vld_q;
   end

   // retried command comes from the buffer under its original tag
   always_ff @(posedge clk)
   begin
      if (rty_vld_q)
      begin
         dma_cmd.cmd <= buf_rd_cmd;
         dma_cmd.tag <= rty_tag_q;
      end
      else
      begin
         dma_cmd.cmd <= new_cmd_q;
         dma_cmd.tag <= new_tag_q;
      end
   end

endmodule

// ==== data_bridge_top.sv ====
/*
 * DMA write-command bridge
 * tag pool, retry control, command buffer and issue logic
 */
`include "bridge_consts.svh"

module data_bridge_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  lcl_cmd_valid,
   input  bridge_pkg::lcl_cmd_t  lcl_cmd,
   output logic                  lcl_cmd_ready,
   input  logic                  dma_cmd_ready,
   output logic                  dma_cmd_valid,
   output bridge_pkg::dma_cmd_t  dma_cmd,
   input  logic                  dma_resp_valid,
   input  bridge_pkg::dma_resp_t dma_resp,
   output logic                  lcl_resp_valid,
   output bridge_pkg::lcl_resp_t lcl_resp,
   output logic                  buf_empty
);

   // pool to issue
   logic [`BR_TAG_W-1:0] free_tag;
   logic                 tag_avail;
   logic                 tag_take;
   // response side to pool and issue
   logic                 rel_valid;
   logic [`BR_TAG_W-1:0] rel_tag;
   logic                 retry_pending;
   logic [`BR_TAG_W-1:0] retry_head;
   logic                 retry_hold;
   logic                 retry_pop;
   // buffer ports
   logic                 buf_wr_en;
   logic [`BR_TAG_W-1:0] buf_wr_tag;
   bridge_pkg::lcl_cmd_t buf_wr_cmd;
   logic [`BR_TAG_W-1:0] buf_rd_tag;
   bridge_pkg::lcl_cmd_t buf_rd_cmd;

   tag_pool tag_pool_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .tag_take  (tag_take),
      .free_tag  (free_tag),
      .tag_avail (tag_avail),
      .rel_valid (rel_valid),
      .rel_tag   (rel_tag),
      .all_free  (buf_empty)
   );

   resp_retry_ctrl resp_retry_ctrl_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .dma_resp_valid (dma_resp_valid),
      .dma_resp       (dma_resp),
      .rel_valid      (rel_valid),
      .rel_tag        (rel_tag),
      .lcl_resp_valid (lcl_resp_valid),
      .lcl_resp       (lcl_resp),
      .retry_pop      (retry_pop),
      .retry_pending  (retry_pending),
      .retry_head     (retry_head),
      .retry_hold     (retry_hold)
   );

   cmd_buffer cmd_buffer_i (
      .clk    (clk),
      .wr_en  (buf_wr_en),
      .wr_tag (buf_wr_tag),
      .wr_cmd (buf_wr_cmd),
      .rd_tag (buf_rd_tag),
      .rd_cmd (buf_rd_cmd)
   );

   cmd_issue cmd_issue_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .lcl_cmd_valid (lcl_cmd_valid),
      .lcl_cmd       (lcl_cmd),
      .lcl_cmd_ready (lcl_cmd_ready),
      .dma_cmd_ready (dma_cmd_ready),
      .dma_cmd_valid (dma_cmd_valid),
      .dma_cmd       (dma_cmd),
      .tag_take      (tag_take),
      .free_tag      (free_tag),
      .tag_avail     (tag_avail),
      .retry_pop     (retry_pop),
      .retry_pending (retry_pending),
      .retry_head    (retry_head),
      .retry_hold    (retry_hold),
      .buf_wr_en     (buf_wr_en),
      .buf_wr_tag    (buf_wr_tag),
      .buf_wr_cmd    (buf_wr_cmd),
      .buf_rd_tag    (buf_rd_tag),
      .buf_rd_cmd    (buf_rd_cmd)
   );

endmodule

// ==== tb_data_bridge.sv ====
/*
 * testbench for the DMA write-command bridge
 * table-driven stimulus, reference model of tags, commands and responses
 */
`include "bridge_consts.svh"

module tb_data_bridge;

   // ====================
   // table and model types
   // ====================

   typedef enum logic [2:0] {
      OP_SEND, OP_DRDY, OP_GOOD, OP_BAD, OP_RETRY, OP_IDLE, OP_WAIT, OP_BLOCK
   } op_e;

   typedef struct packed {
      op_e op;
      int  arg;
   } step_t;

   // expected DMA command, cycle is -1 for a retried one
   typedef struct packed {
      bridge_pkg::dma_cmd_t c;
      int                   cyc;
   } exp_cmd_t;

   typedef struct packed {
      bridge_pkg::lcl_resp_t r;
      int                    cyc;
   } exp_resp_t;

   localparam int NSTEPS = 25;

   logic                  clk;
   logic                  rst_n;
   logic                  lcl_cmd_valid;
   bridge_pkg::lcl_cmd_t  lcl_cmd;
   logic                  lcl_cmd_ready;
   logic                  dma_cmd_ready;
   logic                  dma_cmd_valid;
   bridge_pkg::dma_cmd_t  dma_cmd;
   logic                  dma_resp_valid;
   bridge_pkg::dma_resp_t dma_resp;
   logic                  lcl_resp_valid;
   bridge_pkg::lcl_resp_t lcl_resp;
   logic                  buf_empty;

   step_t                 steps [NSTEPS];
   logic [31:0]           lfsr = 32'd72979;
   int                    cyc = 0;
   int                    low_cyc = 0;
   int                    low_valids = 0;
   logic                  hold_test = 1'b0;
   logic [`BR_TAG_W-1:0]  free_q [$];
   logic [`BR_TAG_W-1:0]  out_q [$];
   bridge_pkg::lcl_cmd_t  send_q [$];
   bridge_pkg::lcl_cmd_t  sent_cmd [`BR_TAGS];
   exp_cmd_t              new_q [$];
   exp_cmd_t              retry_q [$];
   exp_resp_t             resp_q [$];

   data_bridge_top data_bridge_top_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
      cyc <= cyc + 1;

   // ====================
   // helpers
   // ====================

   task automatic stop_on_error();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   // fibonacci LFSR, one step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic bridge_pkg::lcl_cmd_t make_cmd();
      bridge_pkg::lcl_cmd_t c;
      c.data = rand_bits(`BR_DATA_W);
      c.ea   = `BR_EA_W'(rand_bits(`BR_EA_W));
      c.be   = `BR_BE_W'(rand_bits(`BR_BE_W));
      return c;
   endfunction

   // answer the oldest outstanding tags, one response per cycle
   task automatic respond(input bridge_pkg::resp_code_e code, input int n);
      logic [`BR_TAG_W-1:0] t;
      exp_cmd_t             ec;
      exp_resp_t            er;
      for (int i = 0; i < n; i++)
      begin
         @(posedge clk);
         #1;
         assert (out_q.size() > 0) else
         begin
            $display("Error: response step with no outstanding tag");
            stop_on_error();
         end
         t = out_q.pop_front();
         dma_resp_valid = 1'b1;
         dma_resp.tag   = t;
         dma_resp.code  = code;
         if (code == bridge_pkg::RESP_RETRY)
         begin
            // same tag and buffered payload come back later
            ec.c.cmd = sent_cmd[t];
            ec.c.tag = t;
            ec.cyc   = -1;
            retry_q.push_back(ec);
            out_q.push_back(t);
         end
         else
         begin
            er.r.tag = t;
            er.r.ok  = (code == bridge_pkg::RESP_GOOD);
            er.cyc   = cyc + 1;
            resp_q.push_back(er);
            free_q.push_back(t);
         end
      end
      @(posedge clk);
      #1;
      dma_resp_valid = 1'b0;
   endtask

   task automatic wait_idle();
      while (send_q.size() || new_q.size() || retry_q.size() || resp_q.size())
         @(negedge clk);
      repeat (3) @(negedge clk);
      hold_test = 1'b0;
      if (free_q.size() == `BR_TAGS)
         assert (buf_empty) else
         begin
            $display("Error: buf_empty 0x%h expected 0x1", buf_empty);
            stop_on_error();
         end
   endtask

   // ====================
   // command driver
   // ====================

   initial
   begin
      forever
      begin
         @(posedge clk);
         #1;
         lcl_cmd_valid = (send_q.size() > 0);
         if (send_q.size() > 0)
            lcl_cmd = send_q[0];
      end
   end

   // ====================
   // monitor and model
   // ====================

   always @(negedge clk)
   begin
      if (rst_n)
      begin
         exp_cmd_t e;
         if (lcl_cmd_valid && lcl_cmd_ready)
         begin
            assert (free_q.size() > 0 && !(hold_test && retry_q.size() > 0)) else
            begin
               $display("Error: command accepted with no free tag or under retry hold");
               stop_on_error();
            end
            e.c.cmd = send_q.pop_front();
            e.c.tag = free_q.pop_front();
            e.cyc   = cyc + 2;
            new_q.push_back(e);
            out_q.push_back(e.c.tag);
            sent_cmd[e.c.tag] = e.c.cmd;
         end
         if (dma_cmd_valid)
         begin
            assert ((new_q.size() > 0 && new_q[0].cyc == cyc) || retry_q.size() > 0) else
            begin
               $display("Error: unexpected dma_cmd 0x%h", dma_cmd);
               stop_on_error();
            end
            if (new_q.size() > 0 && new_q[0].cyc == cyc)
               e = new_q.pop_front();
            else
               e = retry_q.pop_front();
            assert (dma_cmd == e.c) else
            begin
               $display("Error: dma_cmd 0x%h expected 0x%h", dma_cmd, e.c);
               stop_on_error();
            end
         end
         if (new_q.size() > 0)
            assert (new_q[0].cyc >= cyc) else
            begin
               $display("Error: dma_cmd missing for tag 0x%h", new_q[0].c.tag);
               stop_on_error();
            end
         if (lcl_resp_valid)
         begin
            assert (resp_q.size() > 0 && lcl_resp == resp_q[0].r && resp_q[0].cyc == cyc)
            else
            begin
               $display("Error: lcl_resp 0x%h expected 0x%h", lcl_resp,
                        resp_q.size() ? resp_q[0].r : '0);
               stop_on_error();
            end
            void'(resp_q.pop_front());
         end
         // at most two commands emerge after dma_cmd_ready drops
         if (dma_cmd_ready)
         begin
            low_cyc    = 0;
            low_valids = 0;
         end
         else
         begin
            if (low_cyc >= 1)
            begin
               low_valids += dma_cmd_valid;
               assert (!lcl_cmd_ready && low_valids <= 2) else
               begin
                  $display("Error: lcl_cmd_ready 0x%h dma_cmd count 0x%h after ready drop",
                           lcl_cmd_ready, low_valids);
                  stop_on_error();
               end
            end
            low_cyc++;
         end
      end
   end

   // ====================
   // stimulus table
   // ====================

   initial
   begin
      steps = '{
         '{OP_SEND, 4}, '{OP_IDLE, 0}, '{OP_GOOD, 1}, '{OP_BAD, 1},
         '{OP_RETRY, 2}, '{OP_IDLE, 0}, '{OP_GOOD, 2}, '{OP_IDLE, 0},
         '{OP_SEND, 16}, '{OP_IDLE, 0}, '{OP_BLOCK, 8}, '{OP_GOOD, 3},
         '{OP_IDLE, 0}, '{OP_GOOD, 8}, '{OP_SEND, 4}, '{OP_WAIT, 2},
         '{OP_DRDY, 0}, '{OP_WAIT, 10}, '{OP_DRDY, 1}, '{OP_IDLE, 0},
         '{OP_DRDY, 0}, '{OP_RETRY, 8}, '{OP_WAIT, 4}, '{OP_SEND, 1},
         '{OP_DRDY, 1}
      };
   end

   // watchdog sized from the table
   initial
   begin
      int budget;
      #1;
      budget = 200;
      for (int i = 0; i < NSTEPS; i++)
         budget += 60 + 10 * steps[i].arg;
      #(budget * 4);
      $display("Error: watchdog expired, the bridge stopped making progress");
      stop_on_error();
   end

   initial
   begin
      rst_n          = 1'b0;
      lcl_cmd_valid  = 1'b0;
      lcl_cmd        = '0;
      dma_cmd_ready  = 1'b1;
      dma_resp_valid = 1'b0;
      dma_resp       = '{tag: '0, code: bridge_pkg::RESP_GOOD};
      for (int t = 0; t < `BR_TAGS; t++)
         free_q.push_back(`BR_TAG_W'(t));
      repeat (16) @(posedge clk);
      @(negedge clk);
      assert (!lcl_cmd_ready && !dma_cmd_valid && !lcl_resp_valid) else
      begin
         $display("Error: lcl_cmd_ready 0x%h dma_cmd_valid 0x%h lcl_resp_valid 0x%h expected 0x0",
                  lcl_cmd_ready, dma_cmd_valid, lcl_resp_valid);
         stop_on_error();
      end
      @(posedge clk);
      #1;
      rst_n = 1'b1;
      // wait for the pool fill to finish
      while (!lcl_cmd_ready)
         @(negedge clk);
      assert (buf_empty) else
      begin
         $display("Error: buf_empty 0x%h expected 0x1", buf_empty);
         stop_on_error();
      end
      for (int i = 0; i < NSTEPS; i++)
      begin
         case (steps[i].op)
            OP_SEND:
               for (int k = 0; k < steps[i].arg; k++)
                  send_q.push_back(make_cmd());
            OP_DRDY:
            begin
               @(posedge clk);
               #1;
               dma_cmd_ready = steps[i].arg[0];
            end
            OP_GOOD:  respond(bridge_pkg::RESP_GOOD, steps[i].arg);
            OP_BAD:   respond(bridge_pkg::RESP_BAD, steps[i].arg);
            OP_RETRY:
            begin
               hold_test = (steps[i].arg >= `BR_TAGS / 2);
               respond(bridge_pkg::RESP_RETRY, steps[i].arg);
            end
            OP_WAIT:  repeat (steps[i].arg) @(negedge clk);
            OP_BLOCK:
            begin
               // pool is empty, a waiting command must not get in
               send_q.push_back(make_cmd());
               repeat (steps[i].arg)
               begin
                  @(negedge clk);
                  assert (!lcl_cmd_ready) else
                  begin
                     $display("Error: lcl_cmd_ready 0x%h expected 0x0", lcl_cmd_ready);
                     stop_on_error();
                  end
               end
            end
            default:  wait_idle();
         endcase
      end
      wait_idle();
      respond(bridge_pkg::RESP_GOOD, out_q.size());
      wait_idle();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+.
bridge_pkg.sv
tag_fifo.sv
tag_pool.sv
resp_retry_ctrl.sv
cmd_buffer.sv
cmd_issue.sv
data_bridge_top.sv
tb_data_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
   --top-module tb_data_bridge -f files.f
./obj_dir/Vtb_data_bridge
